// File: hdl/mem_pkg.sv
package mem_pkg;

  // byte address, virtual or physical
  typedef logic [31:0] addr_t;

  // one instruction word
  typedef logic [31:0] word_t;

  // axi arlen, beats minus one
  typedef logic [7:0] burst_len_t;

  // segment field, addr[31:29]
  typedef logic [2:0] seg_top_t;

  // unmapped segments
  localparam seg_top_t KSEG0 = 3'd4;
  localparam seg_top_t KSEG1 = 3'd5;

endpackage

// File: hdl/seg_mapper.sv
`timescale 1ns/1ps

module seg_mapper import mem_pkg::*; (
  input  addr_t addr,
  output addr_t paddr,
  output logic  cached,
  output logic  addr_err
);

  seg_top_t seg;
  logic     is_kseg0;
  logic     is_kseg1;

  assign seg      = addr[31:29];
  assign is_kseg0 = (seg == KSEG0);
  assign is_kseg1 = (seg == KSEG1);

  // both unmapped segments alias the low 512 MB
  assign paddr    = {3'b000, addr[28:0]};
  assign cached   = is_kseg0;

  // no tlb, so mapped segments are errors
  assign addr_err = !(is_kseg0 || is_kseg1);

endmodule

// File: hdl/icache.sv
`timescale 1ns/1ps

module icache import mem_pkg::*; #(
  parameter int LINE_WORDS = 4,
  parameter int SETS       = 64
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  cache_req,
  input  addr_t paddr,
  output logic  hit_ok,
  output word_t hit_data,
  output logic  refill_req,
  output addr_t refill_addr,
  input  logic  beat_valid,
  input  word_t beat_data,
  input  logic  beat_last
);

  localparam int OFFSET_W = $clog2(LINE_WORDS);
  localparam int INDEX_W  = $clog2(SETS);
  localparam int TAG_W    = 30 - OFFSET_W - INDEX_W;

  typedef enum logic [1:0] {
    S_LOOKUP,
    S_REFILL,
    S_RESPOND
  } state_t;

  state_t              state;
  logic                req_valid;
  addr_t               req_addr;
  logic [OFFSET_W-1:0] beat_cnt;

  logic [SETS-1:0]     valid;
  logic [TAG_W-1:0]    tags  [SETS];
  word_t               lines [SETS*LINE_WORDS];

  logic [OFFSET_W-1:0] req_offset;
  logic [INDEX_W-1:0]  req_index;
  logic [TAG_W-1:0]    req_tag;
  logic                tag_match;

  // split the registered address
  assign req_offset = req_addr[OFFSET_W+1:2];
  assign req_index  = req_addr[OFFSET_W+INDEX_W+1:OFFSET_W+2];
  assign req_tag    = req_addr[31:OFFSET_W+INDEX_W+2];
  assign tag_match  = valid[req_index] && (tags[req_index] == req_tag);

  // respond state re-reads the freshly written line
  assign hit_ok      = ((state == S_LOOKUP) && req_valid && tag_match) ||
                       (state == S_RESPOND);
  assign hit_data    = lines[{req_index, req_offset}];
  assign refill_req  = (state == S_LOOKUP) && req_valid && !tag_match;
  assign refill_addr = {req_addr[31:OFFSET_W+2], {(OFFSET_W+2){1'b0}}};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= S_LOOKUP;
      req_valid <= 1'b0;
      beat_cnt  <= '0;
      valid     <= '0;
    end else begin
      case (state)
        S_LOOKUP: begin
          if (refill_req) begin
            state     <= S_REFILL;
            req_valid <= 1'b0;
            beat_cnt  <= '0;
          end else begin
            req_valid <= cache_req;
          end
        end
        S_REFILL: begin
          if (beat_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_last) begin
              valid[req_index] <= 1'b1;
              state            <= S_RESPOND;
            end
          end
        end
        S_RESPOND: begin
          // a new fetch may arrive with this answer
          state     <= S_LOOKUP;
          req_valid <= cache_req;
        end
        default: state <= S_LOOKUP;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cache_req) begin
      req_addr <= paddr;
    end
  end

  // beats arrive in address order from word 0
  always_ff @(posedge clk) begin
    if (state == S_REFILL && beat_valid) begin
      lines[{req_index, beat_cnt}] <= beat_data;
      if (beat_last) begin
        tags[req_index] <= req_tag;
      end
    end
  end

endmodule

// File: hdl/fetch_router.sv
`timescale 1ns/1ps

module fetch_router import mem_pkg::*; #(
  parameter int LINE_WORDS = 4
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       req,
  input  addr_t      paddr,
  input  logic       cached,
  input  logic       map_err,
  output logic       addr_ok,
  output logic       data_ok,
  output word_t      rdata,
  output logic       addr_err,
  output logic       cache_req,
  input  logic       hit_ok,
  input  word_t      hit_data,
  input  logic       refill_req,
  input  addr_t      refill_addr,
  output logic       rd_req,
  output addr_t      rd_addr,
  output burst_len_t rd_len,
  input  logic       beat_valid,
  input  word_t      beat_data
);

  localparam burst_len_t LINE_LEN = burst_len_t'(LINE_WORDS - 1);

  typedef enum logic [1:0] {
    S_READY,
    S_WAIT_CACHE,
    S_WAIT_UNCACHED
  } state_t;

  state_t state;
  logic   err_pend;
  logic   unc_pend;
  word_t  unc_data;
  logic   accept;

  // response source follows the state
  always_comb begin
    addr_ok  = 1'b0;
    data_ok  = 1'b0;
    rdata    = '0;
    addr_err = 1'b0;
    case (state)
      S_READY: begin
        addr_ok  = 1'b1;
        data_ok  = err_pend || unc_pend;
        addr_err = err_pend;
        if (unc_pend) begin
          rdata = unc_data;
        end
      end
      S_WAIT_CACHE: begin
        // a hit frees the port in the same cycle
        addr_ok = hit_ok;
        data_ok = hit_ok;
        rdata   = hit_data;
      end
      default: addr_ok = 1'b0;
    endcase
  end

  assign accept    = req && addr_ok;
  assign cache_req = accept && cached;

  // refill and uncached reads never overlap
  assign rd_req  = refill_req || (accept && !cached && !map_err);
  assign rd_addr = refill_req ? refill_addr : paddr;
  assign rd_len  = refill_req ? LINE_LEN : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= S_READY;
      err_pend <= 1'b0;
      unc_pend <= 1'b0;
    end else begin
      err_pend <= accept && map_err;
      unc_pend <= (state == S_WAIT_UNCACHED) && beat_valid;
      if (accept) begin
        if (map_err) begin
          state <= S_READY;
        end else if (cached) begin
          state <= S_WAIT_CACHE;
        end else begin
          state <= S_WAIT_UNCACHED;
        end
      end else if (state == S_WAIT_CACHE && hit_ok) begin
        state <= S_READY;
      end else if (state == S_WAIT_UNCACHED && beat_valid) begin
        state <= S_READY;
      end
    end
  end

  // single uncached beat, answered next cycle
  always_ff @(posedge clk) begin
    if (state == S_WAIT_UNCACHED && beat_valid) begin
      unc_data <= beat_data;
    end
  end

endmodule

// File: hdl/axi_read_master.sv
`timescale 1ns/1ps

module axi_read_master import mem_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       rd_req,
  input  addr_t      rd_addr,
  input  burst_len_t rd_len,
  output addr_t      araddr,
  output burst_len_t arlen,
  output logic       arvalid,
  input  logic       arready,
  input  word_t      rdata,
  input  logic       rvalid,
  input  logic       rlast,
  output logic       rready,
  output logic       beat_valid,
  output word_t      beat_data,
  output logic       beat_last
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_DATA
  } state_t;

  state_t state;

  assign arvalid    = (state == S_ADDR);
  assign rready     = (state == S_DATA);
  assign beat_valid = rready && rvalid;
  assign beat_data  = rdata;
  // meaningful only with beat_valid
  assign beat_last  = rlast;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (rd_req) begin
            state <= S_ADDR;
          end
        end
        S_ADDR: begin
          if (arready) begin
            state <= S_DATA;
          end
        end
        S_DATA: begin
          if (rvalid && rlast) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // ar fields held until the handshake
  always_ff @(posedge clk) begin
    if (state == S_IDLE && rd_req) begin
      araddr <= rd_addr;
      arlen  <= rd_len;
    end
  end

endmodule

// File: hdl/inst_mem_unit.sv
`timescale 1ns/1ps

module inst_mem_unit import mem_pkg::*; #(
  parameter int LINE_WORDS = 4,
  parameter int SETS       = 64
) (
  input  logic       clk,
  input  logic       arst_n,
  // cpu fetch port
  input  logic       req,
  input  addr_t      addr,
  output logic       addr_ok,
  output logic       data_ok,
  output word_t      rdata,
  output logic       addr_err,
  // axi read channels, r data renamed against the cpu side
  output addr_t      araddr,
  output burst_len_t arlen,
  output logic       arvalid,
  input  logic       arready,
  input  word_t      axi_rdata,
  input  logic       rvalid,
  input  logic       rlast,
  output logic       rready
);

  addr_t      paddr;
  logic       cached;
  logic       map_err;
  logic       cache_req;
  logic       hit_ok;
  word_t      hit_data;
  logic       refill_req;
  addr_t      refill_addr;
  logic       rd_req;
  addr_t      rd_addr;
  burst_len_t rd_len;
  logic       beat_valid;
  word_t      beat_data;
  logic       beat_last;

  seg_mapper u_seg_mapper (
    .addr     (addr),
    .paddr    (paddr),
    .cached   (cached),
    .addr_err (map_err)
  );

  // beats go to both, each takes them only in its wait state
  icache #(
    .LINE_WORDS (LINE_WORDS),
    .SETS       (SETS)
  ) u_icache (
    .clk         (clk),
    .arst_n      (arst_n),
    .cache_req   (cache_req),
    .paddr       (paddr),
    .hit_ok      (hit_ok),
    .hit_data    (hit_data),
    .refill_req  (refill_req),
    .refill_addr (refill_addr),
    .beat_valid  (beat_valid),
    .beat_data   (beat_data),
    .beat_last   (beat_last)
  );

  fetch_router #(
    .LINE_WORDS (LINE_WORDS)
  ) u_fetch_router (
    .clk         (clk),
    .arst_n      (arst_n),
    .req         (req),
    .paddr       (paddr),
    .cached      (cached),
    .map_err     (map_err),
    .addr_ok     (addr_ok),
    .data_ok     (data_ok),
    .rdata       (rdata),
    .addr_err    (addr_err),
    .cache_req   (cache_req),
    .hit_ok      (hit_ok),
    .hit_data    (hit_data),
    .refill_req  (refill_req),
    .refill_addr (refill_addr),
    .rd_req      (rd_req),
    .rd_addr     (rd_addr),
    .rd_len      (rd_len),
    .beat_valid  (beat_valid),
    .beat_data   (beat_data)
  );

  axi_read_master u_axi_read_master (
    .clk        (clk),
    .arst_n     (arst_n),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .rd_len     (rd_len),
    .araddr     (araddr),
    .arlen      (arlen),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (axi_rdata),
    .rvalid     (rvalid),
    .rlast      (rlast),
    .rready     (rready),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .beat_last  (beat_last)
  );

endmodule

// File: tb/tb_inst_mem_unit.sv
`timescale 1ns/1ps

module tb_inst_mem_unit import mem_pkg::*; ();

  // same values as the DUT defaults
  localparam int LINE_WORDS = 4;
  localparam int TIMEOUT    = 2000;
  localparam int K_HIT      = 0;
  localparam int K_REFILL   = 1;
  localparam int K_UNCACHED = 2;
  localparam int K_ERROR    = 3;

  logic       clk = 1'b0;
  logic       arst_n;
  logic       req;
  addr_t      addr;
  logic       addr_ok;
  logic       data_ok;
  word_t      rdata;
  logic       addr_err;
  addr_t      araddr;
  burst_len_t arlen;
  logic       arvalid;
  logic       arready;
  word_t      axi_rdata;
  logic       rvalid;
  logic       rlast;
  logic       rready;

  logic [15:0] lfsr = 16'd30014;
  int          cycle = 0;
  int          mismatches = 0;
  int          failures = 0;
  logic        timed_out = 1'b0;

  // pattern list and the in-flight fetches
  addr_t pat_addr[$];
  int    pat_kind[$];
  addr_t exp_addr[$];
  int    exp_kind[$];
  int    exp_cycle[$];
  addr_t ar_addr_q[$];
  int    ar_len_q[$];

  // axi slave state
  logic       burst_active = 1'b0;
  addr_t      burst_addr;
  int         burst_len;
  int         beat;
  logic       ar_held = 1'b0;
  addr_t      held_addr;
  burst_len_t held_len;

  inst_mem_unit DUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .addr      (addr),
    .addr_ok   (addr_ok),
    .data_ok   (data_ok),
    .rdata     (rdata),
    .addr_err  (addr_err),
    .araddr    (araddr),
    .arlen     (arlen),
    .arvalid   (arvalid),
    .arready   (arready),
    .axi_rdata (axi_rdata),
    .rvalid    (rvalid),
    .rlast     (rlast),
    .rready    (rready)
  );

  always #50 clk = ~clk;

  always @(negedge clk) cycle++;

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic take_bit(output logic b);
    b    = lfsr[15];
    lfsr = lfsr_next(lfsr);
  endtask

  // kseg0 is cached, kseg1 uncached, the rest are errors
  function automatic logic kind_matches_segment(input addr_t a, input int k);
    seg_top_t s;
    s = a[31:29];
    if (k == K_HIT || k == K_REFILL) return s == KSEG0;
    if (k == K_UNCACHED) return s == KSEG1;
    return s != KSEG0 && s != KSEG1;
  endfunction

  task automatic load_patterns();
    int                fd;
    int                n;
    string             line;
    addr_t             a;
    logic [8*8-1:0]    kind;
    fd = $fopen("tb/fetch_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/fetch_patterns.txt");
      failures++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %s", a, kind);
        pat_addr.push_back(a);
        if (kind == "hit") pat_kind.push_back(K_HIT);
        else if (kind == "refill") pat_kind.push_back(K_REFILL);
        else if (kind == "uncached") pat_kind.push_back(K_UNCACHED);
        else pat_kind.push_back(K_ERROR);
        if (!kind_matches_segment(a, pat_kind[$])) begin
          $display("pattern %h has a kind that does not fit its segment", a);
          failures++;
        end
      end
    end
    $fclose(fd);
  endtask

  // slave inputs change on the falling edge only
  always @(negedge clk) begin
    logic b;
    if (arst_n) begin
      take_bit(b);
      arready = b;
      if (burst_active) begin
        take_bit(b);
        rvalid    = b;
        axi_rdata = ~(burst_addr + addr_t'(beat * 4));
        rlast     = (beat == burst_len);
      end else begin
        rvalid = 1'b0;
        rlast  = 1'b0;
      end
    end
  end

  // axi slave bookkeeping first, then the cpu-side checks
  always @(posedge clk) begin
    addr_t pa;
    word_t want;
    if (arst_n) begin
      if (ar_held && !arvalid) begin
        $display("arvalid dropped at %0t before arready", $time);
        failures++;
      end
      if (ar_held && arvalid && araddr != held_addr) begin
        $display("MISMATCH %0t araddr got %h expected %h", $time, araddr, held_addr);
        mismatches++;
      end
      if (ar_held && arvalid && arlen != held_len) begin
        $display("MISMATCH %0t arlen got %0d expected %0d", $time, arlen, held_len);
        mismatches++;
      end
      if (burst_active && !rready) begin
        $display("rready low at %0t with a read outstanding", $time);
        failures++;
      end
      ar_held   = arvalid && !arready;
      held_addr = araddr;
      held_len  = arlen;
      if (arvalid && arready) begin
        ar_addr_q.push_back(araddr);
        ar_len_q.push_back(int'(arlen));
        burst_active = 1'b1;
        burst_addr   = araddr;
        burst_len    = int'(arlen);
        beat         = 0;
      end else if (burst_active && rvalid && rready) begin
        if (beat == burst_len) burst_active = 1'b0;
        beat++;
      end

      if (data_ok) begin
        if (exp_addr.size() == 0) begin
          $display("data_ok at %0t with no fetch outstanding", $time);
          failures++;
        end else begin
          pa   = {3'b000, exp_addr[0][28:0]};
          want = (exp_kind[0] == K_ERROR) ? '0 : ~pa;
          if (rdata !== want) begin
            $display("MISMATCH %0t rdata got %h expected %h", $time, rdata, want);
            mismatches++;
          end
          if (addr_err !== (exp_kind[0] == K_ERROR)) begin
            $display("MISMATCH %0t addr_err got %b expected %b", $time, addr_err,
                     exp_kind[0] == K_ERROR);
            mismatches++;
          end
          if ((exp_kind[0] == K_HIT || exp_kind[0] == K_ERROR) &&
              cycle != exp_cycle[0] + 1) begin
            $display("MISMATCH %0t latency got %0d expected 1", $time,
                     cycle - exp_cycle[0]);
            mismatches++;
          end
          if (exp_kind[0] == K_HIT || exp_kind[0] == K_ERROR) begin
            if (ar_addr_q.size() != 0) begin
              $display("fetch %h at %0t caused a read burst", exp_addr[0], $time);
              failures++;
              ar_addr_q.delete();
              ar_len_q.delete();
            end
          end else if (ar_addr_q.size() != 1) begin
            $display("fetch %h at %0t saw %0d reads instead of one", exp_addr[0], $time,
                     ar_addr_q.size());
            failures++;
            ar_addr_q.delete();
            ar_len_q.delete();
          end else begin
            if (exp_kind[0] == K_REFILL) begin
              pa = pa & ~addr_t'(LINE_WORDS * 4 - 1);
            end
            if (ar_addr_q[0] != pa) begin
              $display("MISMATCH %0t araddr got %h expected %h", $time, ar_addr_q[0], pa);
              mismatches++;
            end
            if (ar_len_q[0] != ((exp_kind[0] == K_REFILL) ? LINE_WORDS - 1 : 0)) begin
              $display("MISMATCH %0t arlen got %0d expected %0d", $time, ar_len_q[0],
                       (exp_kind[0] == K_REFILL) ? LINE_WORDS - 1 : 0);
              mismatches++;
            end
            void'(ar_addr_q.pop_front());
            void'(ar_len_q.pop_front());
          end
          void'(exp_addr.pop_front());
          void'(exp_kind.pop_front());
          void'(exp_cycle.pop_front());
        end
      end
    end
  end

  initial begin
    int waited;
    arst_n    = 1'b0;
    req       = 1'b0;
    addr      = '0;
    arready   = 1'b0;
    axi_rdata = '0;
    rvalid    = 1'b0;
    rlast     = 1'b0;
    load_patterns();
    repeat (16) @(posedge clk);
    @(negedge clk);
    if (!addr_ok || data_ok || arvalid || rready) begin
      $display("outputs not idle during reset");
      failures++;
    end
    arst_n = 1'b1;
    foreach (pat_addr[i]) begin
      if (!timed_out) begin
        @(negedge clk);
        req  = 1'b1;
        addr = pat_addr[i];
        waited = 0;
        do begin
          @(posedge clk);
          waited++;
          // after a miss or uncached fetch the port opens with its answer
          if (addr_ok && !data_ok && i > 0 &&
              (pat_kind[i-1] == K_REFILL || pat_kind[i-1] == K_UNCACHED)) begin
            $display("addr_ok high at %0t before the answer to fetch %h", $time,
                     pat_addr[i-1]);
            failures++;
          end
        end while (!addr_ok && waited < TIMEOUT);
        if (!addr_ok) begin
          $display("fetch %h never accepted", pat_addr[i]);
          failures++;
          timed_out = 1'b1;
        end else begin
          // hits and errors keep the port open for the next fetch
          if (waited != 1 &&
              (i == 0 || pat_kind[i-1] == K_HIT || pat_kind[i-1] == K_ERROR)) begin
            $display("fetch %h waited %0d cycles for addr_ok", pat_addr[i], waited);
            failures++;
          end
          exp_addr.push_back(pat_addr[i]);
          exp_kind.push_back(pat_kind[i]);
          exp_cycle.push_back(cycle);
        end
      end
    end
    @(negedge clk);
    req = 1'b0;
    waited = 0;
    while (exp_addr.size() != 0 && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_addr.size() != 0) begin
      $display("%0d fetches never answered", exp_addr.size());
      failures++;
    end
    repeat (4) @(posedge clk);
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: tb/fetch_patterns.txt
# columns: virtual address (hex), expected access kind
# kinds: hit, refill, uncached, error
a0000100 uncached
80000100 refill
80000104 hit
80000108 hit
8000010c hit
80000100 hit
80000500 refill
80000504 hit
80000104 refill
80000108 hit
00001000 error
c0000000 error
e0000010 error
a0000500 uncached
80002000 refill
80002004 hit
80002008 hit
00400000 error
8000200c hit
a0002004 uncached

// File: compile.f
hdl/mem_pkg.sv
hdl/seg_mapper.sv
hdl/icache.sv
hdl/fetch_router.sv
hdl/axi_read_master.sv
hdl/inst_mem_unit.sv
tb/tb_inst_mem_unit.sv

// File: Makefile
TOP = tb_inst_mem_unit

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary -f compile.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir
